/* logic/bakraid_bus_pkg.sv */
// ============================================================
// bus widths, memory map and I/O port offsets
// byte lane numbering of the RAM array
// ============================================================
`default_nettype none

package bakraid_bus_pkg;

    // word address, bit 0 is implied by the data strobes
    typedef logic [23:1] bus_addr_t;
    typedef logic [15:0] bus_word_t;
    typedef logic [7:0]  lane_data_t;
    typedef logic [7:0]  io_offset_t;   // low byte of the byte address

    // memory map, byte addresses
    localparam logic [23:0] VRAM_BASE   = 24'h20_0000;  // to 0x207FFF
    localparam logic [23:0] WRAM_BASE   = 24'h20_8000;  // to 0x20FFFF
    localparam logic [23:0] GP9001_BASE = 24'h40_0000;  // whole 0x4xxxxx
    localparam logic [23:0] IO_BASE     = 24'h50_0000;  // whole 0x5xxxxx

    // I/O block ports
    localparam io_offset_t IO_INPUTS   = 8'h00;
    localparam io_offset_t IO_SYS_DSW  = 8'h02;
    localparam io_offset_t IO_DSW      = 8'h04;
    localparam io_offset_t IO_VCOUNT   = 8'h06;
    localparam io_offset_t IO_LATCH3   = 8'h10;
    localparam io_offset_t IO_LATCH4   = 8'h12;
    localparam io_offset_t IO_LATCH_W  = 8'h14;
    localparam io_offset_t IO_LATCH2_W = 8'h16;
    localparam io_offset_t IO_EEPROM_R = 8'h18;
    localparam io_offset_t IO_EEPROM_W = 8'h1E;
    localparam logic [3:0] IO_OBJBANK  = 4'hC;  // 0x5000C0 to 0x5000CF

    // GP9001 registers, low nibble of the offset
    localparam logic [3:0] GP_WRITE_REG  = 4'h0;
    localparam logic [3:0] GP_SELECT_REG = 4'h4;
    localparam logic [3:0] GP_RAM_H      = 4'h8;
    localparam logic [3:0] GP_RAM_L      = 4'hA;
    localparam logic [3:0] GP_SET_PTR    = 4'hC;

    // odd lanes carry the upper byte of the word
    localparam int LANE_COUNT   = 4;
    localparam int LANE_WRAM_LO = 0;
    localparam int LANE_WRAM_HI = 1;
    localparam int LANE_VRAM_LO = 2;
    localparam int LANE_VRAM_HI = 3;

endpackage

`default_nettype wire

/* logic/bus_decoder.sv */
// ============================================================
// registered region decode of the 68000 bus
// I/O and GP9001 port selects, byte lane write enables
// ============================================================
`default_nettype none

module bus_decoder import bakraid_bus_pkg::*; #(
    parameter int RAM_AW = 14
) (
    input  wire logic                  clk96,
    input  wire logic                  reset96,
    input  wire bus_addr_t             bus_addr,
    input  wire logic                  rw,
    input  wire logic                  as_n,
    input  wire logic                  uds_n,
    input  wire logic                  lds_n,
    output logic                       ram_sel,
    output logic                       vram_sel,
    output logic                       gp_sel,
    output logic                       io_sel,
    output logic [LANE_COUNT-1:0]      lane_we,
    output logic [RAM_AW-1:0]          lane_addr,
    output io_offset_t                 io_offset,
    output logic                       inputs_cs,
    output logic                       sys_dsw_cs,
    output logic                       dsw_cs,
    output logic                       vcount_cs,
    output logic                       latch3_cs,
    output logic                       latch4_cs,
    output logic                       eeprom_r_cs,
    output logic                       eeprom_w_cs,
    output logic                       latch_w_cs,
    output logic                       latch2_w_cs,
    output logic                       objbank_cs,
    output logic                       gp_read_cs,
    output logic                       gp_write_cs
);

    bus_addr_t addr_q;
    logic      rw_q, uds_q, lds_q;
    logic      rd, wr_lo, wr_hi;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            ram_sel  <= 1'b0;
            vram_sel <= 1'b0;
            gp_sel   <= 1'b0;
            io_sel   <= 1'b0;
            rw_q     <= 1'b1;
            uds_q    <= 1'b1;
            lds_q    <= 1'b1;
        end else begin
            // selects only live while the strobe is down
            vram_sel <= !as_n && bus_addr[23:15] == VRAM_BASE[23:15];
            ram_sel  <= !as_n && bus_addr[23:15] == WRAM_BASE[23:15];
            gp_sel   <= !as_n && bus_addr[23:20] == GP9001_BASE[23:20];
            io_sel   <= !as_n && bus_addr[23:20] == IO_BASE[23:20];
            rw_q     <= rw;
            uds_q    <= uds_n;
            lds_q    <= lds_n;
        end
    end

    always_ff @(posedge clk96) begin
        addr_q <= bus_addr;
    end

    assign lane_addr = addr_q[RAM_AW:1];   // ram repeats inside its region
    assign io_offset = {addr_q[7:1], 1'b0};

    assign rd    = rw_q;
    assign wr_lo = !rw_q && !lds_q;
    assign wr_hi = !rw_q && !uds_q;

    always_comb begin
        lane_we               = '0;
        lane_we[LANE_WRAM_LO] = ram_sel && wr_lo;
        lane_we[LANE_WRAM_HI] = ram_sel && wr_hi;
        lane_we[LANE_VRAM_LO] = vram_sel && wr_lo;
        lane_we[LANE_VRAM_HI] = vram_sel && wr_hi;
    end

    // read ports
    assign inputs_cs   = io_sel && rd && io_offset == IO_INPUTS;
    assign sys_dsw_cs  = io_sel && rd && io_offset == IO_SYS_DSW;
    assign dsw_cs      = io_sel && rd && io_offset == IO_DSW;
    assign vcount_cs   = io_sel && rd && io_offset == IO_VCOUNT;
    assign latch3_cs   = io_sel && rd && io_offset == IO_LATCH3;
    assign latch4_cs   = io_sel && rd && io_offset == IO_LATCH4;
    assign eeprom_r_cs = io_sel && rd && io_offset == IO_EEPROM_R;

    // write ports, byte wide ones sit on the low lane
    assign latch_w_cs  = io_sel && wr_lo && io_offset == IO_LATCH_W;
    assign latch2_w_cs = io_sel && wr_lo && io_offset == IO_LATCH2_W;
    assign eeprom_w_cs = io_sel && wr_lo && io_offset == IO_EEPROM_W;
    assign objbank_cs  = io_sel && !rw_q && io_offset[7:4] == IO_OBJBANK;

    assign gp_read_cs  = gp_sel && rd;
    assign gp_write_cs = gp_sel && !rw_q;

    // VRAM and WRAM compares share bits 23:16, bit 15 must split them
    a_one_region: assert property (@(posedge clk96) disable iff (reset96)
        $onehot0({ram_sel, vram_sel, gp_sel, io_sel}))
        else $error("more than one region selected");

endmodule

`default_nettype wire

/* logic/byte_lane_ram.sv */
// ============================================================
// single byte lane of work or video RAM
// ============================================================
`default_nettype none

module byte_lane_ram import bakraid_bus_pkg::*; #(
    parameter int RAM_AW = 14
) (
    input  wire logic              clk96,
    input  wire logic              we,
    input  wire logic [RAM_AW-1:0] addr,
    input  wire lane_data_t        wdata,
    output lane_data_t             q
);

    lane_data_t mem [2**RAM_AW];

    always_ff @(posedge clk96) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];   // old data on a same-cycle write
    end

endmodule

`default_nettype wire

/* logic/io_registers.sv */
// ============================================================
// sound latches and NMI, EEPROM port and Z80 bus request
// GP9001 op strobes and object bank slot
// ============================================================
`default_nettype none

module io_registers import bakraid_bus_pkg::*; (
    input  wire logic       clk96,
    input  wire logic       reset96,
    input  wire bus_word_t  bus_wdata,
    input  wire io_offset_t io_offset,
    input  wire logic       gp9001_ack,
    input  wire logic       eeprom_sdo,
    input  wire logic       latch_w_cs,
    input  wire logic       latch2_w_cs,
    input  wire logic       eeprom_w_cs,
    input  wire logic       objbank_cs,
    input  wire logic       gp_read_cs,
    input  wire logic       gp_write_cs,
    output logic [7:0]      soundlatch,
    output logic [7:0]      soundlatch2,
    output logic            nmi,
    output logic            eeprom_sclk,
    output logic            eeprom_sdi,
    output logic            eeprom_scs,
    output bus_word_t       eeprom_readback,
    output logic            gp9001_op_select_reg,
    output logic            gp9001_op_write_reg,
    output logic            gp9001_op_write_ram,
    output logic            gp9001_op_read_ram_h,
    output logic            gp9001_op_read_ram_l,
    output logic            gp9001_op_set_ram_ptr,
    output logic            gp9001_op_objectbank_wr,
    output logic [2:0]      gp9001_objectbank_slot
);

    logic z80_bus_request;

    // sound CPU side
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            soundlatch  <= 8'h00;
            soundlatch2 <= 8'h00;
            nmi         <= 1'b0;
        end else begin
            nmi <= latch_w_cs || latch2_w_cs;   // follows the write
            if (latch_w_cs) begin
                soundlatch <= bus_wdata[7:0];
            end else if (latch2_w_cs) begin
                soundlatch2 <= bus_wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            z80_bus_request <= 1'b0;
            eeprom_sclk     <= 1'b0;
            eeprom_sdi      <= 1'b0;
            eeprom_scs      <= 1'b0;
        end else if (eeprom_w_cs) begin
            z80_bus_request <= bus_wdata[4];
            eeprom_sclk     <= bus_wdata[3];
            eeprom_sdi      <= bus_wdata[2];
            eeprom_scs      <= bus_wdata[0];
        end
    end

    assign eeprom_readback = {11'h000, eeprom_sdo, 3'b000, z80_bus_request};

    // strobes hold until the GP9001 acks with the bus idle
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            gp9001_op_select_reg    <= 1'b0;
            gp9001_op_write_reg     <= 1'b0;
            gp9001_op_write_ram     <= 1'b0;
            gp9001_op_read_ram_h    <= 1'b0;
            gp9001_op_read_ram_l    <= 1'b0;
            gp9001_op_set_ram_ptr   <= 1'b0;
            gp9001_op_objectbank_wr <= 1'b0;
            gp9001_objectbank_slot  <= 3'd0;
        end else if (objbank_cs) begin
            gp9001_objectbank_slot  <= io_offset[3:1];
            gp9001_op_objectbank_wr <= 1'b1;
        end else if (gp_read_cs) begin
            case (io_offset[3:0])
                GP_RAM_H: gp9001_op_read_ram_h <= 1'b1;
                GP_RAM_L: gp9001_op_read_ram_l <= 1'b1;
                default: ;
            endcase
        end else if (gp_write_cs) begin
            case (io_offset[3:0])
                GP_WRITE_REG:       gp9001_op_write_reg   <= 1'b1;
                GP_SELECT_REG:      gp9001_op_select_reg  <= 1'b1;
                GP_RAM_H, GP_RAM_L: gp9001_op_write_ram   <= 1'b1;
                GP_SET_PTR:         gp9001_op_set_ram_ptr <= 1'b1;
                default: ;
            endcase
        end else if (gp9001_ack) begin
            gp9001_op_select_reg    <= 1'b0;
            gp9001_op_write_reg     <= 1'b0;
            gp9001_op_write_ram     <= 1'b0;
            gp9001_op_read_ram_h    <= 1'b0;
            gp9001_op_read_ram_l    <= 1'b0;
            gp9001_op_set_ram_ptr   <= 1'b0;
            gp9001_op_objectbank_wr <= 1'b0;
        end
    end

    // latch 2 would be starved by the priority above
    a_latch_excl: assert property (@(posedge clk96) disable iff (reset96)
        !(latch_w_cs && latch2_w_cs))
        else $error("both sound latch writes decoded");

endmodule

`default_nettype wire

/* logic/read_mux.sv */
// ============================================================
// read data multiplexer for the 68000 bus
// cabinet input formatting, video status word
// ============================================================
`default_nettype none

module read_mux import bakraid_bus_pkg::*; (
    input  wire logic                         clk96,
    input  wire logic                         reset96,
    input  wire lane_data_t [LANE_COUNT-1:0]  lane_q,
    input  wire logic                         ram_sel,
    input  wire logic                         vram_sel,
    input  wire logic                         gp_sel,
    input  wire logic                         rw,
    input  wire bus_word_t                    gp9001_dout,
    input  wire logic                         inputs_cs,
    input  wire logic                         sys_dsw_cs,
    input  wire logic                         dsw_cs,
    input  wire logic                         vcount_cs,
    input  wire logic                         latch3_cs,
    input  wire logic                         latch4_cs,
    input  wire logic                         eeprom_r_cs,
    input  wire bus_word_t                    eeprom_readback,
    input  wire logic [9:0]                   joystick1,
    input  wire logic [9:0]                   joystick2,
    input  wire logic [3:0]                   start_button,
    input  wire logic [3:0]                   coin_input,
    input  wire logic                         service,
    input  wire logic                         dip_test,
    input  wire logic [7:0]                   dipsw_a,
    input  wire logic [7:0]                   dipsw_b,
    input  wire logic [7:0]                   dipsw_c,
    input  wire logic [8:0]                   v,
    input  wire logic                         hsync,
    input  wire logic                         vsync,
    input  wire logic                         fblank,
    input  wire logic [7:0]                   soundlatch3,
    input  wire logic [7:0]                   soundlatch4,
    output bus_word_t                         bus_rdata
);

    // pins are active low, the game wants active high
    function automatic logic [7:0] player_byte(input logic [9:0] joy);
        return {1'b0, ~joy[6], ~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    bus_word_t sys_word, video_status, rd_next;

    assign sys_word = {dipsw_c, 1'b0, ~start_button[1], ~start_button[0],
                       ~coin_input[1], ~coin_input[0], ~dip_test, 1'b0, ~service};

    // line count saturates past the visible 256
    assign video_status = {hsync, vsync, 5'b11111, fblank, v[8] ? 8'hFF : v[7:0]};

    always_comb begin
        if (ram_sel)          rd_next = {lane_q[LANE_WRAM_HI], lane_q[LANE_WRAM_LO]};
        else if (vram_sel)    rd_next = {lane_q[LANE_VRAM_HI], lane_q[LANE_VRAM_LO]};
        else if (gp_sel)      rd_next = gp9001_dout;
        else if (inputs_cs)   rd_next = {player_byte(joystick2), player_byte(joystick1)};
        else if (sys_dsw_cs)  rd_next = sys_word;
        else if (dsw_cs)      rd_next = {dipsw_b, dipsw_a};
        else if (vcount_cs)   rd_next = video_status;
        else if (latch3_cs)   rd_next = {8'h00, soundlatch3};
        else if (latch4_cs)   rd_next = {8'h00, soundlatch4};
        else if (eeprom_r_cs) rd_next = eeprom_readback;
        else                  rd_next = '0;   // unmapped
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            bus_rdata <= '0;
        end else if (rw) begin   // writes leave the last read in place
            bus_rdata <= rd_next;
        end
    end

    a_rdata_reset: assert property (@(posedge clk96) $fell(reset96) |=> bus_rdata == '0)
        else $error("bus_rdata not zero one cycle after reset");

endmodule

`default_nettype wire

/* logic/main_bus.sv */
// ============================================================
// main CPU bus glue: decoder, RAM lanes, I/O registers
// and read multiplexer
// ============================================================
`default_nettype none

module main_bus import bakraid_bus_pkg::*; #(
    parameter int RAM_AW = 14
) (
    input  wire logic       clk96,
    input  wire logic       reset96,
    input  wire bus_addr_t  bus_addr,
    input  wire bus_word_t  bus_wdata,
    input  wire logic       rw,
    input  wire logic       as_n,
    input  wire logic       uds_n,
    input  wire logic       lds_n,
    output bus_word_t       bus_rdata,
    input  wire logic [9:0] joystick1,
    input  wire logic [9:0] joystick2,
    input  wire logic [3:0] start_button,
    input  wire logic [3:0] coin_input,
    input  wire logic       service,
    input  wire logic       dip_test,
    input  wire logic [7:0] dipsw_a,
    input  wire logic [7:0] dipsw_b,
    input  wire logic [7:0] dipsw_c,
    input  wire logic [8:0] v,
    input  wire logic       hsync,
    input  wire logic       vsync,
    input  wire logic       fblank,
    input  wire bus_word_t  gp9001_dout,
    input  wire logic       gp9001_ack,
    output logic            gp9001_op_select_reg,
    output logic            gp9001_op_write_reg,
    output logic            gp9001_op_write_ram,
    output logic            gp9001_op_read_ram_h,
    output logic            gp9001_op_read_ram_l,
    output logic            gp9001_op_set_ram_ptr,
    output logic            gp9001_op_objectbank_wr,
    output logic [2:0]      gp9001_objectbank_slot,
    input  wire logic [7:0] soundlatch3,
    input  wire logic [7:0] soundlatch4,
    output logic [7:0]      soundlatch,
    output logic [7:0]      soundlatch2,
    output logic            nmi,
    input  wire logic       eeprom_sdo,
    output logic            eeprom_sclk,
    output logic            eeprom_sdi,
    output logic            eeprom_scs
);

    logic                        ram_sel, vram_sel, gp_sel, io_sel;
    logic [LANE_COUNT-1:0]       lane_we;
    logic [RAM_AW-1:0]           lane_addr;
    lane_data_t [LANE_COUNT-1:0] lane_q;
    io_offset_t                  io_offset;
    bus_word_t                   eeprom_readback;
    logic inputs_cs, sys_dsw_cs, dsw_cs, vcount_cs, latch3_cs, latch4_cs;
    logic eeprom_r_cs, eeprom_w_cs, latch_w_cs, latch2_w_cs;
    logic objbank_cs, gp_read_cs, gp_write_cs;

    bus_decoder #(.RAM_AW(RAM_AW)) u_decoder (
        .clk96, .reset96, .bus_addr, .rw, .as_n, .uds_n, .lds_n,
        .ram_sel, .vram_sel, .gp_sel, .io_sel,
        .lane_we, .lane_addr, .io_offset,
        .inputs_cs, .sys_dsw_cs, .dsw_cs, .vcount_cs, .latch3_cs, .latch4_cs,
        .eeprom_r_cs, .eeprom_w_cs, .latch_w_cs, .latch2_w_cs,
        .objbank_cs, .gp_read_cs, .gp_write_cs
    );

    // odd lanes take the upper data byte
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        byte_lane_ram #(.RAM_AW(RAM_AW)) u_lane (
            .clk96 (clk96),
            .we    (lane_we[i]),
            .addr  (lane_addr),
            .wdata (bus_wdata[8*(i%2) +: 8]),
            .q     (lane_q[i])
        );
    end

    io_registers u_io_regs (
        .clk96, .reset96, .bus_wdata, .io_offset, .gp9001_ack, .eeprom_sdo,
        .latch_w_cs, .latch2_w_cs, .eeprom_w_cs, .objbank_cs,
        .gp_read_cs, .gp_write_cs,
        .soundlatch, .soundlatch2, .nmi,
        .eeprom_sclk, .eeprom_sdi, .eeprom_scs, .eeprom_readback,
        .gp9001_op_select_reg, .gp9001_op_write_reg, .gp9001_op_write_ram,
        .gp9001_op_read_ram_h, .gp9001_op_read_ram_l, .gp9001_op_set_ram_ptr,
        .gp9001_op_objectbank_wr, .gp9001_objectbank_slot
    );

    read_mux u_read_mux (
        .clk96, .reset96, .lane_q, .ram_sel, .vram_sel, .gp_sel, .rw,
        .gp9001_dout,
        .inputs_cs, .sys_dsw_cs, .dsw_cs, .vcount_cs, .latch3_cs, .latch4_cs,
        .eeprom_r_cs, .eeprom_readback,
        .joystick1, .joystick2, .start_button, .coin_input, .service, .dip_test,
        .dipsw_a, .dipsw_b, .dipsw_c,
        .v, .hsync, .vsync, .fblank, .soundlatch3, .soundlatch4,
        .bus_rdata
    );

endmodule

`default_nettype wire

/* testbench/tb_main_bus.sv */
// ============================================================
// testbench for the main CPU bus glue: clock, reset, 68000
// read and write tasks, stimulus, assertions, closing report
// ============================================================
`default_nettype none

module tb_main_bus import bakraid_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCESS_COUNT = 62;   // bus cycles over all tests
    localparam int CYCLE_LIMIT  = 6 * ACCESS_COUNT + 100;

    logic       clk96, reset96;
    bus_addr_t  bus_addr;
    bus_word_t  bus_wdata, bus_rdata;
    logic       rw, as_n, uds_n, lds_n;
    logic [9:0] joystick1, joystick2;
    logic [3:0] start_button, coin_input;
    logic       service, dip_test;
    logic [7:0] dipsw_a, dipsw_b, dipsw_c;
    logic [8:0] v;
    logic       hsync, vsync, fblank;
    bus_word_t  gp9001_dout;
    logic       gp9001_ack;
    logic       gp9001_op_select_reg, gp9001_op_write_reg, gp9001_op_write_ram;
    logic       gp9001_op_read_ram_h, gp9001_op_read_ram_l, gp9001_op_set_ram_ptr;
    logic       gp9001_op_objectbank_wr;
    logic [2:0] gp9001_objectbank_slot;
    logic [7:0] soundlatch3, soundlatch4, soundlatch, soundlatch2;
    logic       nmi, eeprom_sdo, eeprom_sclk, eeprom_sdi, eeprom_scs;

    logic [6:0]  gp_strobes;
    logic [31:0] lcg_state;
    logic        nmi_mid_write;   // nmi seen in the middle of the last write
    int          error_count;
    int          check_count;
    int          cycle_count;

    // bit 0 select_reg up to bit 6 objectbank_wr
    assign gp_strobes = {gp9001_op_objectbank_wr, gp9001_op_set_ram_ptr, gp9001_op_read_ram_l,
                         gp9001_op_read_ram_h, gp9001_op_write_ram, gp9001_op_write_reg,
                         gp9001_op_select_reg};

    main_bus #(.RAM_AW(14)) i_dut (.*);

    initial begin
        clk96 = 1'b0;
        forever #50 clk96 = ~clk96;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk96);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    a_one_strobe: assert property (@(posedge clk96) disable iff (reset96) $onehot0(gp_strobes))
        else begin
            error_count++;
            $display("more than one GP9001 op strobe is high at once");
        end

    // no strobe may drop while the ack is low
    a_strobe_held: assert property (@(posedge clk96) disable iff (reset96)
        !gp9001_ack |=> ($past(gp_strobes) & ~gp_strobes) == 7'd0)
        else begin
            error_count++;
            $display("a GP9001 op strobe dropped before gp9001_ack");
        end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] expected_player_byte(input logic [9:0] joy);
        int         src [7];
        logic [7:0] b;
        src = '{3, 2, 1, 0, 4, 5, 6};   // byte bit n from joystick bit src[n]
        b = 8'h00;
        for (int n = 0; n < 7; n++) begin
            b[n] = ~joy[src[n]];
        end
        return b;
    endfunction

    function automatic bus_word_t expected_system_word(input logic [7:0] dsw_c,
            input logic [3:0] start, input logic [3:0] coin, input logic test,
            input logic svc);
        bus_word_t w;
        w = {dsw_c, 8'h00};
        w[6] = ~start[1];
        w[5] = ~start[0];
        w[4] = ~coin[1];
        w[3] = ~coin[0];
        w[2] = ~test;
        w[0] = ~svc;
        return w;
    endfunction

    function automatic bus_word_t expected_video_status(input logic hs, input logic vs,
            input logic fb, input logic [8:0] line);
        bus_word_t w;
        w = 16'h3E00;   // bits 13 to 9 read as ones
        w[15] = hs;
        w[14] = vs;
        w[8] = fb;
        w[7:0] = (line < 9'd256) ? line[7:0] : 8'hFF;
        return w;
    endfunction

    task automatic check_word(input string name, input bus_word_t expected,
            input bus_word_t got);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("[FAIL] %s expected %h got %h", name, expected, got);
        end
    endtask

    task automatic release_bus();
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        rw    <= 1'b1;
        repeat (2) @(posedge clk96);
    endtask

    // called right after a rising edge, as_n low for 4 clocks
    task automatic bus_write(input logic [23:0] byte_addr, input bus_word_t data,
            input logic upper, input logic lower);
        bus_addr  <= byte_addr[23:1];
        bus_wdata <= data;
        rw        <= 1'b0;
        uds_n     <= ~upper;
        lds_n     <= ~lower;
        as_n      <= 1'b0;
        repeat (3) @(posedge clk96);
        @(negedge clk96);
        nmi_mid_write = nmi;
        @(posedge clk96);
        release_bus();
    endtask

    task automatic bus_read(input logic [23:0] byte_addr, output bus_word_t data);
        bus_addr <= byte_addr[23:1];
        rw       <= 1'b1;
        uds_n    <= 1'b0;
        lds_n    <= 1'b0;
        as_n     <= 1'b0;
        repeat (3) @(posedge clk96);
        @(negedge clk96);
        data = bus_rdata;   // fourth clock of the cycle
        @(posedge clk96);
        release_bus();
    endtask

    task automatic read_check(input logic [23:0] byte_addr, input bus_word_t expected);
        bus_word_t got;
        bus_read(byte_addr, got);
        check_word($sformatf("bus_rdata at %h", byte_addr), expected, got);
    endtask

    // strobe must hold without ack and clear after one ack cycle
    task automatic hold_until_ack(input string name, input logic [6:0] mask);
        @(negedge clk96);
        check_word(name, 16'(mask), 16'(gp_strobes));
        @(posedge clk96);
        @(negedge clk96);
        check_word({name, " held"}, 16'(mask), 16'(gp_strobes));
        @(posedge clk96);
        gp9001_ack <= 1'b1;
        @(posedge clk96);
        gp9001_ack <= 1'b0;
        @(negedge clk96);
        check_word({name, " after ack"}, 16'h0000, 16'(gp_strobes));
        @(posedge clk96);
    endtask

    task automatic test_ram();
        logic [23:0] offs [4];
        bus_word_t   wram_exp [4];
        bus_word_t   vram_exp [4];
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            offs[i] = (24'(i) << 13) | {11'd0, r[12:1], 1'b0};   // one per quarter
            wram_exp[i] = r[31:16];
            r = next_random();
            vram_exp[i] = r[31:16];
            bus_write(24'h20_8000 + offs[i], wram_exp[i], 1'b1, 1'b1);
            bus_write(24'h20_0000 + offs[i], vram_exp[i], 1'b1, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            read_check(24'h20_8000 + offs[i], wram_exp[i]);
            read_check(24'h20_0000 + offs[i], vram_exp[i]);
        end
        r = next_random();
        bus_write(24'h20_8000 + offs[0], r[31:16], 1'b0, 1'b1);   // low byte only
        wram_exp[0] = {wram_exp[0][15:8], r[23:16]};
        read_check(24'h20_8000 + offs[0], wram_exp[0]);
        read_check(24'h20_0000 + offs[0], vram_exp[0]);
    endtask

    task automatic test_cabinet();
        logic [31:0] r1, r2;
        for (int i = 0; i < 3; i++) begin
            r1 = next_random();
            r2 = next_random();
            joystick1    <= r1[9:0];
            joystick2    <= r1[19:10];
            start_button <= r1[23:20];
            coin_input   <= r1[27:24];
            service      <= r1[28];
            dip_test     <= r1[29];
            dipsw_a      <= r2[7:0];
            dipsw_b      <= r2[15:8];
            dipsw_c      <= r2[23:16];
            read_check(24'h50_0000,
                {expected_player_byte(r1[19:10]), expected_player_byte(r1[9:0])});
            read_check(24'h50_0002,
                expected_system_word(r2[23:16], r1[23:20], r1[27:24], r1[29], r1[28]));
            read_check(24'h50_0004, r2[15:0]);
        end
    endtask

    task automatic test_video();
        logic [31:0] r;
        logic [8:0]  line;
        for (int k = 0; k < 16; k++) begin
            r = next_random();
            line = {k[3], r[7:0]};
            if (k == 0) begin
                line = 9'd255;   // last visible line
            end
            if (k == 8) begin
                line = 9'd256;
            end
            hsync  <= k[0];
            vsync  <= k[1];
            fblank <= k[2];
            v      <= line;
            read_check(24'h50_0006, expected_video_status(k[0], k[1], k[2], line));
        end
    endtask

    task automatic test_latches();
        logic [31:0] r;
        r = next_random();
        bus_write(24'h50_0014, r[15:0], 1'b1, 1'b1);
        @(negedge clk96);
        check_word("soundlatch", 16'(r[7:0]), 16'(soundlatch));
        check_word("nmi during write", 16'd1, 16'(nmi_mid_write));
        check_word("nmi after write", 16'd0, 16'(nmi));
        @(posedge clk96);
        bus_write(24'h50_0016, r[31:16], 1'b1, 1'b1);
        @(negedge clk96);
        check_word("soundlatch2", 16'(r[23:16]), 16'(soundlatch2));
        check_word("soundlatch", 16'(r[7:0]), 16'(soundlatch));
        check_word("nmi during write", 16'd1, 16'(nmi_mid_write));
        @(posedge clk96);
        r = next_random();
        soundlatch3 <= r[7:0];
        soundlatch4 <= r[15:8];
        read_check(24'h50_0010, {8'h00, r[7:0]});
        read_check(24'h50_0012, {8'h00, r[15:8]});
    endtask

    task automatic test_gp9001();
        logic [3:0]  wr_off [5];
        logic [6:0]  wr_mask [5];
        logic [31:0] r;
        wr_off  = '{4'h0, 4'h4, 4'h8, 4'hA, 4'hC};
        wr_mask = '{7'h02, 7'h01, 7'h04, 7'h04, 7'h20};
        for (int i = 0; i < 5; i++) begin
            r = next_random();
            bus_write(24'h40_0000 | 24'(wr_off[i]), r[15:0], 1'b1, 1'b1);
            hold_until_ack("gp9001_op write strobes", wr_mask[i]);
        end
        r = next_random();
        gp9001_dout <= r[15:0];
        read_check(24'h40_0008, r[15:0]);
        hold_until_ack("gp9001_op_read_ram_h", 7'h08);
        gp9001_dout <= r[31:16];
        read_check(24'h40_000A, r[31:16]);
        hold_until_ack("gp9001_op_read_ram_l", 7'h10);
        bus_write(24'h50_00C6, 16'h0000, 1'b1, 1'b1);
        @(negedge clk96);
        check_word("gp9001_objectbank_slot", 16'd3, 16'(gp9001_objectbank_slot));
        @(posedge clk96);
        hold_until_ack("gp9001_op_objectbank_wr", 7'h40);
    endtask

    task automatic test_eeprom_unmapped();
        logic [31:0] r;
        bus_word_t   data;
        logic        sdo_bit;
        for (int i = 0; i < 2; i++) begin
            r = next_random();
            data = (i == 0) ? (r[15:0] & ~16'h001D) : (r[15:0] | 16'h001D);
            sdo_bit = (i == 1);
            eeprom_sdo <= sdo_bit;
            bus_write(24'h50_001E, data, 1'b1, 1'b1);
            @(negedge clk96);
            check_word("eeprom_sclk", 16'(data[3]), 16'(eeprom_sclk));
            check_word("eeprom_sdi", 16'(data[2]), 16'(eeprom_sdi));
            check_word("eeprom_scs", 16'(data[0]), 16'(eeprom_scs));
            @(posedge clk96);
            read_check(24'h50_0018, {11'd0, sdo_bit, 3'd0, data[4]});
        end
        read_check(24'h30_0000, 16'h0000);   // nothing mapped here
        read_check(24'h50_0020, 16'h0000);   // hole in the I/O block
    endtask

    initial begin
        lcg_state   = 32'h65d9_29dd;
        error_count = 0;
        check_count = 0;
        reset96      <= 1'b1;
        bus_addr     <= '0;
        bus_wdata    <= '0;
        rw           <= 1'b1;
        as_n         <= 1'b1;
        uds_n        <= 1'b1;
        lds_n        <= 1'b1;
        joystick1    <= '1;
        joystick2    <= '1;
        start_button <= '1;
        coin_input   <= '1;
        service      <= 1'b1;
        dip_test     <= 1'b1;
        dipsw_a      <= 8'h00;
        dipsw_b      <= 8'h00;
        dipsw_c      <= 8'h00;
        v            <= 9'd0;
        hsync        <= 1'b0;
        vsync        <= 1'b0;
        fblank       <= 1'b0;
        gp9001_dout  <= 16'h0000;
        gp9001_ack   <= 1'b0;
        soundlatch3  <= 8'h00;
        soundlatch4  <= 8'h00;
        eeprom_sdo   <= 1'b0;
        repeat (3) @(posedge clk96);
        reset96 <= 1'b0;
        @(negedge clk96);
        check_word("bus_rdata after reset", 16'h0000, bus_rdata);
        check_word("soundlatch after reset", 16'h0000, 16'(soundlatch));
        check_word("soundlatch2 after reset", 16'h0000, 16'(soundlatch2));
        check_word("nmi after reset", 16'h0000, 16'(nmi));
        check_word("gp9001_op strobes after reset", 16'h0000, 16'(gp_strobes));
        check_word("eeprom outputs after reset", 16'h0000,
            16'({eeprom_sclk, eeprom_sdi, eeprom_scs}));
        @(posedge clk96);
        test_ram();
        test_cabinet();
        test_video();
        test_latches();
        test_gp9001();
        test_eeprom_unmapped();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/bakraid_bus_pkg.sv
logic/bus_decoder.sv
logic/byte_lane_ram.sv
logic/io_registers.sv
logic/read_mux.sv
logic/main_bus.sv
testbench/tb_main_bus.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the main bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_main_bus -f src.f

sim_output=$(./obj_dir/Vtb_main_bus || true)
echo "$sim_output"

if grep -qx "TESTBENCH PASSED" <<< "$sim_output"; then
    exit 0
fi
exit 1
